//--- verilog/md5Pkg.sv
////////////////////
// MD5 algorithm definitions shared by the hash pipeline
// state word layout, the message block with its two views,
// the standard initial values and the per-step constant tables
// import with md5Pkg::* in the module header
////////////////////
package md5Pkg;

	localparam int stepCount = 64;	// steps in one MD5 block

	typedef logic [31:0] md5Word;

	// a sits in the low word so the state reads directly as the digest
	typedef struct packed
	{
		md5Word d;
		md5Word c;
		md5Word b;
		md5Word a;
	} md5State;

	// one 512 bit message block
	// bytes[0] is the first message byte and the low byte of words[0]
	typedef union packed
	{
		md5Word [15:0] words;	// step view
		logic [63:0][7:0] bytes;	// padder view
	} msgBlock;

	localparam md5State md5Init = '{
		a: 32'h67452301,
		b: 32'hefcdab89,
		c: 32'h98badcfe,
		d: 32'h10325476
	};

	//////////////////// additive constants, floor(abs(sin(i+1)) * 2^32)
	localparam md5Word stepAdd [0:63] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,	// round 1
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,	// round 2
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,	// round 3
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,	// round 4
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	//////////////////// left rotate amounts
	localparam logic [4:0] stepShift [0:63] = '{
		5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
		5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
		5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
		5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21,
		5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21
	};

endpackage

//--- verilog/searchPkg.sv
////////////////////
// search data definitions
// candidate words, runtime configuration, the item that travels
// down the hash pipeline and the result stream record
////////////////////
package searchPkg;

	import md5Pkg::*;

	localparam int maxCandidateLen = 8;	// keeps padding inside one block

	// byte 0 is the first character, unused bytes are zero
	typedef logic [maxCandidateLen-1:0][7:0] candidate;

	typedef struct packed
	{
		logic [7:0] rangeMin;	// lowest character code
		logic [7:0] rangeMax;	// highest character code
		logic [127:0] targetDigest;	// little endian, first byte in [7:0]
	} searchConfig;

	// one pipeline slot, valid low marks a bubble
	typedef struct packed
	{
		logic valid;
		md5State state;	// running a, b, c, d
		msgBlock block;	// padded message, constant along the chain
		candidate word;	// plain text travels with its hash
	} pipeItem;

	typedef struct packed
	{
		logic valid;	// one cycle strobe per hashed candidate
		logic [127:0] digest;
		candidate word;
	} searchResult;

endpackage

//--- verilog/candidateGenerator.sv
`timescale 1ns/1ps
////////////////////
// candidate source for the hash pipeline
// odometer over printable characters, character 0 is the fastest digit
// one valid item per clock while run is high, a bubble otherwise
////////////////////
module candidateGenerator import searchPkg::*; #(
	parameter int unsigned candidateLen = 4	// characters per candidate, 1 to 8
) (
	input  logic       clk,
	input  logic       resetGenerator,	// async, active low
	input  logic [7:0] rangeMin,
	input  logic [7:0] rangeMax,
	input  logic       run,	// level, no handshake
	output pipeItem    item
);

	logic [candidateLen-1:0][7:0] offsetQ;	// digit distance from rangeMin
	logic [candidateLen-1:0][7:0] offsetNext;
	logic carry;	// ripple through the digits
	candidate chars;	// count as characters
	logic validQ;
	candidate wordQ;

	// offsets reset to zero so the count starts at all rangeMin
	always_comb
	begin
		chars = '0;
		for (int i = 0; i < candidateLen; i++)
		begin
			chars[i] = rangeMin + offsetQ[i];
		end
	end

	// next count, a digit at rangeMax folds back and carries
	always_comb
	begin
		carry = 1'b1;
		offsetNext = offsetQ;
		for (int i = 0; i < candidateLen; i++)
		begin
			if (carry)
			begin
				if (chars[i] >= rangeMax)
					offsetNext[i] = '0;	// carry moves on
				else
				begin
					offsetNext[i] = offsetQ[i] + 8'd1;
					carry = 1'b0;
				end
			end
		end
		// carry out of the last digit leaves all zero, count wraps
	end

	always_ff @(posedge clk or negedge resetGenerator)
	begin
		if (!resetGenerator)
		begin
			offsetQ <= '0;
			validQ <= 1'b0;
		end
		else
		begin
			validQ <= run;
			if (run)
				offsetQ <= offsetNext;	// advance only on taken samples
		end
	end

	always_ff @(posedge clk)
	begin
		wordQ <= run ? chars : '0;
	end

	always_comb
	begin
		item = '0;	// state and block come from the builder
		item.valid = validQ;
		item.word = wordQ;
	end

endmodule

//--- verilog/blockBuilder.sv
`timescale 1ns/1ps
////////////////////
// MD5 padder, one cycle
// puts a short candidate into a single message block with the 80h marker
// and the bit length, and loads the standard initial state
////////////////////
module blockBuilder import md5Pkg::*; import searchPkg::*; #(
	parameter int unsigned candidateLen = 4
) (
	input  logic    clk,
	input  logic    resetGenerator,
	input  pipeItem inItem,
	output pipeItem outItem
);

	localparam logic [63:0] msgBits = 64'(candidateLen * 8);	// message length in bits

	msgBlock padded;
	logic validQ;
	md5State stateQ;
	msgBlock blockQ;
	candidate wordQ;

	//////////////////// padding through the byte view
	always_comb
	begin
		padded = '0;
		for (int i = 0; i < candidateLen; i++)
		begin
			padded.bytes[i] = inItem.word[i];
		end
		padded.bytes[candidateLen] = 8'h80;	// marker right after the text
		for (int j = 0; j < 8; j++)
		begin
			padded.bytes[56 + j] = msgBits[8*j +: 8];	// little endian length
		end
	end

	always_ff @(posedge clk or negedge resetGenerator)
	begin
		if (!resetGenerator)
			validQ <= 1'b0;
		else
			validQ <= inItem.valid;
	end

	always_ff @(posedge clk)
	begin
		if (inItem.valid)
		begin
			stateQ <= md5Init;
			blockQ <= padded;
		end
		else
		begin
			stateQ <= inItem.state;	// bubble goes through as is
			blockQ <= inItem.block;
		end
		wordQ <= inItem.word;
	end

	assign outItem = '{valid: validQ, state: stateQ, block: blockQ, word: wordQ};

endmodule

//--- verilog/md5Step.sv
`timescale 1ns/1ps
////////////////////
// one registered MD5 step
// stepIndex picks the round function, the message word and the constants,
// so 64 copies in a row hash one block per clock
////////////////////
module md5Step import md5Pkg::*; import searchPkg::*; #(
	parameter int stepIndex = 0	// 0 to 63
) (
	input  logic    clk,
	input  logic    resetGenerator,
	input  pipeItem inItem,
	output pipeItem outItem
);

	localparam int round = stepIndex / 16;
	// message word schedule per round
	localparam int msgIndex = (round == 0) ? stepIndex :
		(round == 1) ? (5 * stepIndex + 1) % 16 :
		(round == 2) ? (3 * stepIndex + 5) % 16 :
		(7 * stepIndex) % 16;
	localparam md5Word addConst = stepAdd[stepIndex];
	localparam logic [4:0] rot = stepShift[stepIndex];

	md5State s;	// incoming state
	md5Word mix;	// round function
	md5Word sum;
	md5Word rotated;
	md5State nextState;
	logic validQ;
	md5State stateQ;
	msgBlock blockQ;
	candidate wordQ;

	assign s = inItem.state;

	always_comb
	begin
		case (round)
			0: mix = (s.b & s.c) | (~s.b & s.d);	// F
			1: mix = (s.d & s.b) | (~s.d & s.c);	// G
			2: mix = s.b ^ s.c ^ s.d;	// H
			default: mix = s.c ^ (s.b | ~s.d);	// I
		endcase
		sum = s.a + mix + addConst + inItem.block.words[msgIndex];
		rotated = (sum << rot) | (sum >> (32 - rot));	// rotate left, rot never 0
		// words shift one place, only b gets new data
		nextState = '{a: s.d, b: s.b + rotated, c: s.b, d: s.c};
	end

	always_ff @(posedge clk or negedge resetGenerator)
	begin
		if (!resetGenerator)
			validQ <= 1'b0;
		else
			validQ <= inItem.valid;
	end

	always_ff @(posedge clk)
	begin
		stateQ <= inItem.valid ? nextState : inItem.state;	// bubbles untouched
		blockQ <= inItem.block;
		wordQ <= inItem.word;
	end

	assign outItem = '{valid: validQ, state: stateQ, block: blockQ, word: wordQ};

endmodule

//--- verilog/digestChecker.sv
`timescale 1ns/1ps
////////////////////
// pipeline tail
// adds the initial state to finish the digest, streams every result
// and keeps the first candidate whose digest hits the target
////////////////////
module digestChecker import md5Pkg::*; import searchPkg::*; (
	input  logic         clk,
	input  logic         resetGenerator,
	input  logic [127:0] targetDigest,
	input  pipeItem      inItem,
	output searchResult  result,
	output logic         found,	// sticky until reset
	output candidate     foundWord	// first match only
);

	md5State finalState;
	logic [127:0] digest;
	logic isMatch;
	logic resultValid;
	logic [127:0] digestQ;
	candidate wordQ;

	// feed forward of the block's start state
	assign finalState = '{
		a: inItem.state.a + md5Init.a,
		b: inItem.state.b + md5Init.b,
		c: inItem.state.c + md5Init.c,
		d: inItem.state.d + md5Init.d
	};
	assign digest = finalState;	// a lands in the low bytes
	assign isMatch = inItem.valid && (digest == targetDigest);

	always_ff @(posedge clk or negedge resetGenerator)
	begin
		if (!resetGenerator)
		begin
			resultValid <= 1'b0;
			found <= 1'b0;
			foundWord <= '0;
		end
		else
		begin
			resultValid <= inItem.valid;	// bubbles give no strobe
			if (isMatch && !found)
			begin
				found <= 1'b1;
				foundWord <= inItem.word;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		digestQ <= digest;
		wordQ <= inItem.word;
	end

	assign result = '{valid: resultValid, digest: digestQ, word: wordQ};

endmodule

//--- verilog/md5Search.sv
`timescale 1ns/1ps
////////////////////
// pipelined MD5 password search, top level
// generator, padder, 64 step chain and checker, one candidate per clock
// hold cfg stable while run is high, results follow 66 clocks later
////////////////////
module md5Search import md5Pkg::*; import searchPkg::*; #(
	parameter int unsigned candidateLen = 4	// 1 to maxCandidateLen
) (
	input  logic        clk,
	input  logic        resetGenerator,	// async, active low
	input  searchConfig cfg,
	input  logic        run,
	output searchResult result,
	output logic        found,
	output candidate    foundWord
);

	// 0 generator, 1 builder, i+2 step i
	pipeItem chain [0:stepCount+1];

	candidateGenerator #(
		.candidateLen(candidateLen)
	) generator_i (
		.clk(clk),
		.resetGenerator(resetGenerator),
		.rangeMin(cfg.rangeMin),
		.rangeMax(cfg.rangeMax),
		.run(run),
		.item(chain[0])
	);

	blockBuilder #(
		.candidateLen(candidateLen)
	) builder_i (
		.clk(clk),
		.resetGenerator(resetGenerator),
		.inItem(chain[0]),
		.outItem(chain[1])
	);

	//////////////////// hash steps
	for (genvar i = 0; i < stepCount; i++)
	begin : gStep
		md5Step #(
			.stepIndex(i)
		) step_i (
			.clk(clk),
			.resetGenerator(resetGenerator),
			.inItem(chain[i + 1]),
			.outItem(chain[i + 2])
		);
	end

	digestChecker checker_i (
		.clk(clk),
		.resetGenerator(resetGenerator),
		.targetDigest(cfg.targetDigest),
		.inItem(chain[stepCount + 1]),
		.result(result),
		.found(found),
		.foundWord(foundWord)
	);

endmodule

//--- sim/md5Ref.svh
////////////////////
// testbench reference model included inside the testbench module
// plain MD5 of one short candidate, the odometer order of candidates
// and the Fibonacci LFSR behind the run pattern
////////////////////
`ifndef MD5REF_SVH
`define MD5REF_SVH

// additive constant of step i straight from the sine definition
function automatic logic [31:0] sineConst(input int i);
	real x;
	longint k;
	x = $sin(real'(i + 1));
	if (x < 0.0)
		x = -x;
	k = longint'($floor(x * 4294967296.0));
	return k[31:0];
endfunction

// MD5 of a candidate of len characters in one block with a little endian digest
function automatic logic [127:0] md5Digest(input candidate w, input int len);
	int shiftTab [0:15];
	logic [31:0] m [0:15];
	logic [31:0] a, b, c, d, f, t, sum;
	logic [63:0] bits;
	int g;
	int s;
	shiftTab = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
	for (int i = 0; i < 16; i++)
		m[i] = '0;
	for (int i = 0; i < len; i++)
		m[i / 4][8 * (i % 4) +: 8] = w[i];
	m[len / 4][8 * (len % 4) +: 8] = 8'h80;	// padding marker
	bits = 64'(len * 8);
	m[14] = bits[31:0];
	m[15] = bits[63:32];
	a = 32'h67452301;
	b = 32'hefcdab89;
	c = 32'h98badcfe;
	d = 32'h10325476;
	for (int i = 0; i < 64; i++)
	begin
		// round function
		case (i / 16)
			0: f = (b & c) | (~b & d);
			1: f = (d & b) | (~d & c);
			2: f = b ^ c ^ d;
			default: f = c ^ (b | ~d);
		endcase
		// message word order of the round
		case (i / 16)
			0: g = i;
			1: g = (5 * i + 1) % 16;
			2: g = (3 * i + 5) % 16;
			default: g = (7 * i) % 16;
		endcase
		sum = a + f + sineConst(i) + m[g];
		s = shiftTab[(i / 16) * 4 + i % 4];
		t = d;
		d = c;
		c = b;
		b = b + ((sum << s) | (sum >> (32 - s)));
		a = t;
	end
	return {d + 32'h10325476, c + 32'h98badcfe, b + 32'hefcdab89, a + 32'h67452301};
endfunction

// first candidate after reset has all characters at lo
function automatic candidate firstCandidate(input logic [7:0] lo, input int len);
	candidate w;
	w = '0;
	for (int i = 0; i < len; i++)
		w[i] = lo;
	return w;
endfunction

// odometer step where character 0 moves fastest and a full carry wraps to all lo
function automatic candidate nextCandidate(input candidate w, input int len,
	input logic [7:0] lo, input logic [7:0] hi);
	for (int i = 0; i < len; i++)
	begin
		if (w[i] < hi)
		begin
			w[i] = w[i] + 8'd1;
			return w;
		end
		w[i] = lo;	// digit folds back and carries on
	end
	return w;
endfunction

// taps of x^32 + x^22 + x^2 + x + 1 with the new bit entering at bit 0
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

//--- sim/md5SearchTb.sv
`timescale 1ns/1ps
////////////////////
// testbench for the pipelined MD5 search
// runs candidates through the DUT, follows every result against the
// reference MD5 and the odometer order, and watches the found latch
////////////////////
module md5SearchTb import searchPkg::*; ();

	localparam int wordLen = 4;
	localparam int testCount = 6;
	localparam int issuedTotal = 40 + 60 + 20;	// candidates over all runs
	localparam int cycleLimit = issuedTotal + 66 * testCount + 100;

	logic clk;
	logic resetGenerator;
	searchConfig cfg;
	logic run;
	searchResult result;
	logic found;
	candidate foundWord;

	int edgeCount = 0;	// rising edges since time 0
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int orderMisses = 0;
	int digestMisses = 0;
	int foundMisses = 0;
	int testMisses;
	int resultCount;
	int firstRunEdge;
	int firstResultEdge;
	candidate expWord;	// next candidate due at the output
	logic expFound;
	candidate expFoundWord;
	candidate seenWords [$];

	`include "md5Ref.svh"

	md5Search #(
		.candidateLen(wordLen)
	) dut_i (
		.clk(clk),
		.resetGenerator(resetGenerator),
		.cfg(cfg),
		.run(run),
		.result(result),
		.found(found),
		.foundWord(foundWord)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////// cycle count and timeout
	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
		if (edgeCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, results stopped arriving", edgeCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string what, input logic [127:0] got,
		input logic [127:0] exp, inout int misses);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
			misses++;
		end
	endtask

	//////////////////// compare process samples settled outputs at the falling edge
	always @(negedge clk)
	begin
		logic [127:0] expDigest;
		if (resetGenerator)
		begin
			if (result.valid)
			begin
				expDigest = md5Digest(expWord, wordLen);
				checkValue("result word", result.word, expWord, orderMisses);
				checkValue("result digest", result.digest, expDigest, digestMisses);
				if (!expFound && expDigest == cfg.targetDigest)
				begin
					expFound = 1'b1;	// first hit only
					expFoundWord = expWord;
				end
				if (resultCount == 0)
					firstResultEdge = edgeCount;
				seenWords.push_back(result.word);
				resultCount++;
				expWord = nextCandidate(expWord, wordLen, cfg.rangeMin, cfg.rangeMax);
			end
			checkValue("found", found, expFound, foundMisses);
			checkValue("foundWord", foundWord, expFoundWord, foundMisses);
		end
	end

	// reset for 4 cycles and restart expectations at all rangeMin
	task automatic applyReset();
		resetGenerator = 1'b0;
		run = 1'b0;
		expWord = firstCandidate(cfg.rangeMin, wordLen);
		expFound = 1'b0;
		expFoundWord = '0;
		repeat (4) @(posedge clk);
		#1 resetGenerator = 1'b1;
	endtask

	// run held high for n samples
	task automatic runCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#1 run = 1'b1;
			if (i == 0)
				firstRunEdge = edgeCount + 1;	// edge that samples it
		end
		@(posedge clk);
		#1 run = 1'b0;
	endtask

	task automatic waitResults(input int n);
		while (resultCount < n)
			@(posedge clk);
		repeat (3) @(posedge clk);	// room for a stray extra strobe
		#1;
	endtask

	task automatic finishTest(input string name, input int misses);
		if (misses == 0)
		begin
			passCount++;
			$display("%s: ok", name);
		end
		else
		begin
			failCount++;
			$display("%s: %0d mismatches", name, misses);
		end
	endtask

	//////////////////// test sequence
	initial
	begin
		candidate probe;
		int orderMark;
		int digestMark;
		int foundMark;
		int highs;
		logic [31:0] lfsr;
		resetGenerator = 1'b0;
		run = 1'b0;
		cfg = '0;
		cfg.rangeMin = "a";
		cfg.rangeMax = "z";
		probe = firstCandidate(cfg.rangeMin, wordLen);
		repeat (24) probe = nextCandidate(probe, wordLen, cfg.rangeMin, cfg.rangeMax);
		cfg.targetDigest = md5Digest(probe, wordLen);	// 25th candidate
		applyReset();

		testMisses = 0;	// idle outputs
		repeat (10)
		begin
			@(posedge clk);
			#1;
			checkValue("idle result.valid", result.valid, 1'b0, testMisses);
			checkValue("idle found", found, 1'b0, testMisses);
			checkValue("idle foundWord", foundWord, '0, testMisses);
		end
		finishTest("test 1 idle after reset", testMisses);

		orderMark = orderMisses;
		digestMark = digestMisses;
		foundMark = foundMisses;
		testMisses = 0;
		resultCount = 0;
		runCycles(40);
		waitResults(40);
		checkValue("result count", resultCount, 40, testMisses);
		checkValue("first latency", firstResultEdge - firstRunEdge, 66, testMisses);
		checkValue("first candidate", seenWords[0], 64'h61616161, testMisses);
		finishTest("test 2 ordered run", testMisses + orderMisses - orderMark);
		finishTest("test 3 digests", digestMisses - digestMark);
		testMisses = 0;
		checkValue("found after run", found, 1'b1, testMisses);
		checkValue("foundWord after run", foundWord, probe, testMisses);
		finishTest("test 4 target hit", testMisses + foundMisses - foundMark);

		orderMark = orderMisses;	// gaps from the LFSR
		digestMark = digestMisses;
		foundMark = foundMisses;
		testMisses = 0;
		resultCount = 0;
		highs = 0;
		lfsr = 32'h4101_d8f3;
		for (int i = 0; i < 60; i++)
		begin
			lfsr = lfsrNext(lfsr);
			@(posedge clk);
			#1 run = lfsr[0];
			highs += lfsr[0];
		end
		@(posedge clk);
		#1 run = 1'b0;
		waitResults(highs);
		checkValue("gapped result count", resultCount, highs, testMisses);
		finishTest("test 5 gapped run",
			testMisses + orderMisses - orderMark + digestMisses - digestMark
			+ foundMisses - foundMark);

		cfg.rangeMin = "a";	// two letters give 16 candidates per lap
		cfg.rangeMax = "b";
		probe = nextCandidate(firstCandidate("a", wordLen), wordLen, "a", "b");
		cfg.targetDigest = md5Digest(probe, wordLen);
		applyReset();
		orderMark = orderMisses;
		digestMark = digestMisses;
		foundMark = foundMisses;
		testMisses = 0;
		resultCount = 0;
		seenWords.delete();
		runCycles(20);
		waitResults(20);
		checkValue("wrap result count", resultCount, 20, testMisses);
		checkValue("candidate 17", seenWords[16], 64'h61616161, testMisses);
		checkValue("found after wrap", found, 1'b1, testMisses);
		checkValue("foundWord after wrap", foundWord, probe, testMisses);
		finishTest("test 6 wrap and first match",
			testMisses + orderMisses - orderMark + digestMisses - digestMark
			+ foundMisses - foundMark);

		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+sim
verilog/md5Pkg.sv
verilog/searchPkg.sv
verilog/candidateGenerator.sv
verilog/blockBuilder.sv
verilog/md5Step.sv
verilog/digestChecker.sv
verilog/md5Search.sv
sim/md5SearchTb.sv
